// ==== common/ccu_cd_params.svh ====
//////////////////////////////////////////////////////////////////////
// CCU snoop-data routing parameters
// Port count, beat width and queue depths
//////////////////////////////////////////////////////////////////////

`ifndef CCU_CD_PARAMS_SVH
`define CCU_CD_PARAMS_SVH

// Number of cache ports returning CD beats
`define CCU_NUM_PORTS 4

// Width of one CD data word
`define CCU_CD_WIDTH 64

// Pending data-carrying requests
`define CCU_REQ_DEPTH 4

// Entries in each output stream buffer
`define CCU_OUT_DEPTH 4

`endif

// ==== common/ccu_cd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// CCU snoop-data path types
// Beats, port index, port mask and data destination
//////////////////////////////////////////////////////////////////////

`include "ccu_cd_params.svh"

package ccu_cd_pkg;

    // Cache port addressing
    typedef logic [$clog2(`CCU_NUM_PORTS)-1:0] port_idx_t;
    typedef logic [`CCU_NUM_PORTS-1:0]         port_mask_t;

    // One CD data word
    typedef logic [`CCU_CD_WIDTH-1:0] cd_word_t;

    // Data word plus last flag, 65 bits
    typedef struct packed {
        cd_word_t data;
        logic     last;
    } cd_beat_t;

    // Where the first responder's data goes
    typedef enum logic {
        DEST_MEMORY = 1'b0,
        DEST_SNOOP  = 1'b1
    } cd_dest_e;

endpackage

// ==== common/ccu_op_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// CCU coherency opcodes and their data classification
//////////////////////////////////////////////////////////////////////

package ccu_op_pkg;

    import ccu_cd_pkg::*;

    typedef enum logic [1:0] {
        OP_NO_DATA       = 2'd0,
        OP_READ_SNP_DATA = 2'd1,
        OP_WRITE_BACK_R  = 2'd2,
        OP_WRITE_BACK_W  = 2'd3
    } ccu_op_e;

    // Returns whether snoop data follows, and where it goes
    function automatic logic op_needs_data(input ccu_op_e op, output cd_dest_e dest);
        dest = DEST_MEMORY;
        case (op)
            OP_READ_SNP_DATA: dest = DEST_SNOOP;
            OP_WRITE_BACK_R,
            OP_WRITE_BACK_W:  dest = DEST_MEMORY;
            default:          return 1'b0;
        endcase
        return 1'b1;
    endfunction

endpackage

// ==== cd_route/cd_request_queue.sv ====
//////////////////////////////////////////////////////////////////////
// CD request queue
// Grants coherency requests and keeps data-carrying ones in order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ccu_cd_params.svh"

module cd_request_queue import ccu_cd_pkg::*; import ccu_op_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       req_valid_i,
    input  ccu_op_e    req_op_i,
    input  port_idx_t  req_first_i,
    input  port_mask_t req_mask_i,
    output logic       req_gnt_o,
    output logic       head_valid_o,
    output cd_dest_e   head_dest_o,
    output port_idx_t  head_first_o,
    output port_mask_t head_mask_o,
    input  logic       head_pop_i
);

    localparam int unsigned Depth = `CCU_REQ_DEPTH;
    localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW  = $clog2(Depth + 1);

    cd_dest_e   dest_q  [Depth];
    port_idx_t  first_q [Depth];
    port_mask_t mask_q  [Depth];

    logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0] count_q;

    logic     needs_data;
    cd_dest_e req_dest;
    logic     empty, full;
    logic     push, wr_en, rd_en;

    always_comb begin
        needs_data = op_needs_data(req_op_i, req_dest);
    end

    assign empty = (count_q == '0);
    assign full  = (count_q == CntW'(Depth));

    // No-data requests bypass the ring entirely
    assign req_gnt_o = !full || !needs_data;
    assign push      = req_valid_i && needs_data && !full;

    // An entry that retires the cycle it arrives is never written
    assign wr_en = push && !(empty && head_pop_i);
    assign rd_en = head_pop_i && !empty;

    // Fall-through head
    assign head_valid_o = !empty || push;
    assign head_dest_o  = empty ? req_dest    : dest_q[rd_ptr_q];
    assign head_first_o = empty ? req_first_i : first_q[rd_ptr_q];
    assign head_mask_o  = empty ? req_mask_i  : mask_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            dest_q[wr_ptr_q]  <= req_dest;
            first_q[wr_ptr_q] <= req_first_i;
            mask_q[wr_ptr_q]  <= req_mask_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntW'(wr_en) - CntW'(rd_en);
        end
    end

    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        head_pop_i |-> head_valid_o);

    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_gnt_o |=> req_valid_i && $stable(req_op_i)
            && $stable(req_first_i) && $stable(req_mask_i));

endmodule

// ==== cd_route/cd_beat_select.sv ====
//////////////////////////////////////////////////////////////////////
// CD beat selection
// Accepts masked beats, forwards the first responder, retires the head
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ccu_cd_params.svh"

module cd_beat_select import ccu_cd_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Head of the request queue
    input  logic                         head_valid_i,
    input  cd_dest_e                     head_dest_i,
    input  port_idx_t                    head_first_i,
    input  port_mask_t                   head_mask_i,
    output logic                         head_pop_o,
    // Per-port CD inputs
    input  port_mask_t                   cd_valid_i,
    input  cd_word_t [`CCU_NUM_PORTS-1:0] cd_data_i,
    input  port_mask_t                   cd_last_i,
    output port_mask_t                   cd_ready_o,
    // Toward the output buffers
    input  logic                         mem_full_i,
    input  logic                         snp_full_i,
    output logic                         mem_push_o,
    output logic                         snp_push_o,
    output cd_beat_t                     beat_o
);

    // Ports that already delivered their last beat for the head entry
    port_mask_t last_q;

    port_mask_t xfer;
    port_mask_t done_mask;
    logic       dest_full;
    logic       first_xfer;
    logic       done;

    assign dest_full = (head_dest_i == DEST_MEMORY) ? mem_full_i : snp_full_i;

    //////////////////////////////////////////////////////////////////////
    // Per-port ready
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
            cd_ready_o[i] = head_valid_i && head_mask_i[i] && !last_q[i];
            // First responder waits for room downstream
            if (port_idx_t'(i) == head_first_i && dest_full) begin
                cd_ready_o[i] = 1'b0;
            end
        end
    end

    assign xfer = cd_valid_i & cd_ready_o;

    //////////////////////////////////////////////////////////////////////
    // Retire
    //////////////////////////////////////////////////////////////////////

    // Includes last beats landing this cycle, so an empty mask retires at once
    assign done_mask  = last_q | (xfer & cd_last_i);
    assign done       = head_valid_i && ((done_mask & head_mask_i) == head_mask_i);
    assign head_pop_o = done;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (done) begin
            last_q <= '0;
        end else begin
            last_q <= done_mask;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////////////////////////

    // Other responders are accepted above and simply dropped here
    assign first_xfer = xfer[head_first_i];

    assign beat_o.data = cd_data_i[head_first_i];
    assign beat_o.last = cd_last_i[head_first_i];

    assign mem_push_o = first_xfer && (head_dest_i == DEST_MEMORY);
    assign snp_push_o = first_xfer && (head_dest_i == DEST_SNOOP);

    // Head entry holds until it retires, so last_q stays meaningful
    a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        head_valid_i && !head_pop_o |=> head_valid_i && $stable(head_dest_i)
            && $stable(head_first_i) && $stable(head_mask_i));

endmodule

// ==== source/cd_beat_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// CD output buffer
// Registered FIFO feeding one destination stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module cd_beat_buffer import ccu_cd_pkg::*; #(
    parameter int unsigned DEPTH = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  cd_beat_t beat_i,
    output logic     full_o,
    output logic     valid_o,
    output cd_word_t data_o,
    output logic     last_o,
    input  logic     ready_i
);

    localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CntW = $clog2(DEPTH + 1);

    cd_beat_t mem_q [DEPTH];

    logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            pop;

    assign full_o  = (count_q == CntW'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q].data;
    assign last_o  = mem_q[rd_ptr_q].last;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= beat_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntW'(push_i) - CntW'(pop);
        end
    end

    // Stalled output must hold its beat
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(last_o));

endmodule

// ==== source/ccu_cd_router.sv ====
//////////////////////////////////////////////////////////////////////
// CCU snoop-data router
// Routes the first responder's CD beats to memory or snoop stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ccu_cd_params.svh"

module ccu_cd_router import ccu_cd_pkg::*; import ccu_op_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Coherency requests
    input  logic                         req_valid_i,
    input  ccu_op_e                      req_op_i,
    input  port_idx_t                    req_first_i,
    input  port_mask_t                   req_mask_i,
    output logic                         req_gnt_o,
    // CD beats from the cache ports
    input  port_mask_t                   cd_valid_i,
    input  cd_word_t [`CCU_NUM_PORTS-1:0] cd_data_i,
    input  port_mask_t                   cd_last_i,
    output port_mask_t                   cd_ready_o,
    // Write-back data toward memory
    output logic                         mem_valid_o,
    output cd_word_t                     mem_data_o,
    output logic                         mem_last_o,
    input  logic                         mem_ready_i,
    // Snoop data back to the requester
    output logic                         snp_valid_o,
    output cd_word_t                     snp_data_o,
    output logic                         snp_last_o,
    input  logic                         snp_ready_i
);

    logic       head_valid;
    cd_dest_e   head_dest;
    port_idx_t  head_first;
    port_mask_t head_mask;
    logic       head_pop;

    logic       mem_push, snp_push;
    logic       mem_full, snp_full;
    cd_beat_t   beat;

    cd_request_queue i_cd_request_queue (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_op_i,
        .req_first_i,
        .req_mask_i,
        .req_gnt_o,
        .head_valid_o (head_valid),
        .head_dest_o  (head_dest),
        .head_first_o (head_first),
        .head_mask_o  (head_mask),
        .head_pop_i   (head_pop)
    );

    cd_beat_select i_cd_beat_select (
        .clk_i,
        .rst_ni,
        .head_valid_i (head_valid),
        .head_dest_i  (head_dest),
        .head_first_i (head_first),
        .head_mask_i  (head_mask),
        .head_pop_o   (head_pop),
        .cd_valid_i,
        .cd_data_i,
        .cd_last_i,
        .cd_ready_o,
        .mem_full_i   (mem_full),
        .snp_full_i   (snp_full),
        .mem_push_o   (mem_push),
        .snp_push_o   (snp_push),
        .beat_o       (beat)
    );

    cd_beat_buffer #(
        .DEPTH (`CCU_OUT_DEPTH)
    ) i_mem_buffer (
        .clk_i,
        .rst_ni,
        .push_i  (mem_push),
        .beat_i  (beat),
        .full_o  (mem_full),
        .valid_o (mem_valid_o),
        .data_o  (mem_data_o),
        .last_o  (mem_last_o),
        .ready_i (mem_ready_i)
    );

    cd_beat_buffer #(
        .DEPTH (`CCU_OUT_DEPTH)
    ) i_snp_buffer (
        .clk_i,
        .rst_ni,
        .push_i  (snp_push),
        .beat_i  (beat),
        .full_o  (snp_full),
        .valid_o (snp_valid_o),
        .data_o  (snp_data_o),
        .last_o  (snp_last_o),
        .ready_i (snp_ready_i)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== verif/tb_ccu_cd_router.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the CCU snoop-data router
// Table of requests, per-port beat drivers, stream checkers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ccu_cd_params.svh"

module tb_ccu_cd_router import ccu_cd_pkg::*; import ccu_op_pkg::*; ();

    localparam int NUM_PORTS      = `CCU_NUM_PORTS;
    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

    // One request with the beat count each port returns
    typedef struct packed {
        ccu_op_e                     op;
        port_idx_t                   first;
        port_mask_t                  mask;
        logic [NUM_PORTS-1:0][3:0]   beats;
    } row_t;

    logic clk, rst_n;

    logic                      req_valid;
    ccu_op_e                   req_op;
    port_idx_t                 req_first;
    port_mask_t                req_mask;
    logic                      req_gnt;
    port_mask_t                cd_valid;
    cd_word_t [NUM_PORTS-1:0]  cd_data;
    port_mask_t                cd_last;
    port_mask_t                cd_ready;
    logic                      mem_valid, mem_last, mem_ready;
    logic                      snp_valid, snp_last, snp_ready;
    cd_word_t                  mem_data, snp_data;

    row_t        rows [NUM_ROWS];
    logic [64:0] mem_exp [$];
    logic [64:0] snp_exp [$];
    logic        hold_cd;
    port_mask_t  port_done;
    int          cycle_count = 0;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) i_tb_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    ccu_cd_router i_ccu_cd_router (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .req_valid_i (req_valid),
        .req_op_i    (req_op),
        .req_first_i (req_first),
        .req_mask_i  (req_mask),
        .req_gnt_o   (req_gnt),
        .cd_valid_i  (cd_valid),
        .cd_data_i   (cd_data),
        .cd_last_i   (cd_last),
        .cd_ready_o  (cd_ready),
        .mem_valid_o (mem_valid),
        .mem_data_o  (mem_data),
        .mem_last_o  (mem_last),
        .mem_ready_i (mem_ready),
        .snp_valid_o (snp_valid),
        .snp_data_o  (snp_data),
        .snp_last_o  (snp_last),
        .snp_ready_i (snp_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Row, port and beat number packed into one word
    function automatic cd_word_t beat_word(input int row, input int port, input int beat);
        return {16'hcd5a, 16'(row), 16'(port), 16'(beat)};
    endfunction

    function automatic row_t make_row(input ccu_op_e op, input port_idx_t first,
                                      input port_mask_t mask, input int b0, input int b1,
                                      input int b2, input int b3);
        row_t r;
        r.op       = op;
        r.first    = first;
        r.mask     = mask;
        r.beats[0] = 4'(b0);
        r.beats[1] = 4'(b1);
        r.beats[2] = 4'(b2);
        r.beats[3] = 4'(b3);
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t ns: %s: got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // First five rows carry data so the queue fills while CD is held
    task automatic load_table();
        rows[0]  = make_row(OP_WRITE_BACK_R,  2'd0, 4'b0011, 4, 2, 0, 0);
        rows[1]  = make_row(OP_READ_SNP_DATA, 2'd2, 4'b0110, 0, 1, 3, 0);
        rows[2]  = make_row(OP_WRITE_BACK_W,  2'd3, 4'b1001, 2, 0, 0, 4);
        rows[3]  = make_row(OP_READ_SNP_DATA, 2'd1, 4'b1111, 1, 3, 2, 1);
        rows[4]  = make_row(OP_WRITE_BACK_R,  2'd2, 4'b0100, 0, 0, 2, 0);
        rows[5]  = make_row(OP_NO_DATA,       2'd0, 4'b1111, 0, 0, 0, 0);
        rows[6]  = make_row(OP_READ_SNP_DATA, 2'd0, 4'b0000, 0, 0, 0, 0);
        rows[7]  = make_row(OP_READ_SNP_DATA, 2'd3, 4'b1000, 0, 0, 0, 4);
        rows[8]  = make_row(OP_WRITE_BACK_W,  2'd1, 4'b0111, 2, 4, 1, 0);
        rows[9]  = make_row(OP_NO_DATA,       2'd1, 4'b0000, 0, 0, 0, 0);
        rows[10] = make_row(OP_READ_SNP_DATA, 2'd0, 4'b0001, 4, 0, 0, 0);
        rows[11] = make_row(OP_READ_SNP_DATA, 2'd1, 4'b0011, 1, 4, 0, 0);
        rows[12] = make_row(OP_WRITE_BACK_R,  2'd2, 4'b1100, 0, 0, 4, 3);
        rows[13] = make_row(OP_WRITE_BACK_W,  2'd0, 4'b0000, 0, 0, 0, 0);
        rows[14] = make_row(OP_READ_SNP_DATA, 2'd3, 4'b1010, 0, 2, 0, 4);
        rows[15] = make_row(OP_WRITE_BACK_R,  2'd1, 4'b0010, 0, 3, 0, 0);
    endtask

    // Only the first responder's beats reach a stream
    task automatic build_expected();
        int          f;
        int          n;
        logic [64:0] entry;
        for (int r = 0; r < NUM_ROWS; r++) begin
            f = int'(rows[r].first);
            n = int'(rows[r].beats[f]);
            if (rows[r].op != OP_NO_DATA && rows[r].mask[f]) begin
                for (int b = 0; b < n; b++) begin
                    entry = {beat_word(r, f, b), (b == n - 1)};
                    if (rows[r].op == OP_READ_SNP_DATA) begin
                        snp_exp.push_back(entry);
                    end else begin
                        mem_exp.push_back(entry);
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Requests
    //////////////////////////////////////////////////////////////////////

    initial begin
        req_valid = 1'b0;
        req_op    = OP_WRITE_BACK_R;
        req_first = '0;
        req_mask  = '0;
        hold_cd   = 1'b1;
        load_table();
        build_expected();

        wait (rst_n === 1'b1);
        @(posedge clk);
        check_value("mem_valid after reset", mem_valid, '0);
        check_value("snp_valid after reset", snp_valid, '0);
        check_value("cd_ready after reset", cd_ready, '0);
        check_value("req_gnt after reset", req_gnt, 64'd1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            req_valid <= 1'b1;
            req_op    <= rows[r].op;
            req_first <= rows[r].first;
            req_mask  <= rows[r].mask;
            // Queue is full and CD still held
            if (r == `CCU_REQ_DEPTH) begin
                repeat (4) begin
                    @(posedge clk);
                    check_value("req_gnt with full queue", req_gnt, '0);
                end
                hold_cd <= 1'b0;
            end
            @(posedge clk);
            if (rows[r].op == OP_NO_DATA || r < `CCU_REQ_DEPTH) begin
                check_value("immediate req_gnt", req_gnt, 64'd1);
            end
            while (!req_gnt) @(posedge clk);
        end
        req_valid <= 1'b0;

        while (!((&port_done) && mem_exp.size() == 0 && snp_exp.size() == 0)) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        check_value("mem_valid at end", mem_valid, '0);
        check_value("snp_valid at end", snp_valid, '0);
        check_value("cd_ready at end", cd_ready, '0);
        $display("Everything OK");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // CD beat drivers, one per port
    //////////////////////////////////////////////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_drv
        initial begin
            logic [31:0] rnd;
            int          gap;
            int          n;
            rnd = lcg_next(32'h65cf + 32'(p));
            cd_valid[p]  <= 1'b0;
            cd_data[p]   <= '0;
            cd_last[p]   <= 1'b0;
            port_done[p] <= 1'b0;
            wait (rst_n === 1'b1);
            @(posedge clk);
            while (hold_cd) @(posedge clk);
            for (int r = 0; r < NUM_ROWS; r++) begin
                n = int'(rows[r].beats[p]);
                if (rows[r].op != OP_NO_DATA && rows[r].mask[p]) begin
                    for (int b = 0; b < n; b++) begin
                        rnd = lcg_next(rnd);
                        gap = (rnd[18:16] > 3'd5) ? int'(rnd[18:16]) - 5 : 0;
                        if (gap > 0) begin
                            cd_valid[p] <= 1'b0;
                            repeat (gap) @(posedge clk);
                        end
                        cd_valid[p] <= 1'b1;
                        cd_data[p]  <= beat_word(r, p, b);
                        cd_last[p]  <= (b == n - 1);
                        @(posedge clk);
                        while (!cd_ready[p]) @(posedge clk);
                    end
                end
            end
            cd_valid[p]  <= 1'b0;
            port_done[p] <= 1'b1;
        end
    end

    // Random output back-pressure that mostly stalls
    initial begin
        logic [31:0] rnd;
        rnd = 32'h65cf;
        mem_ready <= 1'b0;
        snp_ready <= 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            rnd = lcg_next(rnd);
            mem_ready <= (rnd[30:28] > 3'd4);
            snp_ready <= (rnd[26:24] > 3'd4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stream checkers and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [64:0] exp;
        if (mem_valid && mem_ready) begin
            if (mem_exp.size() == 0) begin
                abort_run("Memory stream delivered a beat that no request asked for");
            end else begin
                exp = mem_exp.pop_front();
                check_value("mem_data", mem_data, exp[64:1]);
                check_value("mem_last", mem_last, exp[0]);
            end
        end
    end

    always @(posedge clk) begin
        logic [64:0] exp;
        if (snp_valid && snp_ready) begin
            if (snp_exp.size() == 0) begin
                abort_run("Snoop stream delivered a beat that no request asked for");
            end else begin
                exp = snp_exp.pop_front();
                check_value("snp_data", snp_data, exp[64:1]);
                check_value("snp_last", snp_last, exp[0]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the run did not finish within the cycle limit");
        end
    end

endmodule

// ==== ccu_cd_router.f ====
+incdir+common
common/ccu_cd_pkg.sv
common/ccu_op_pkg.sv
cd_route/cd_request_queue.sv
cd_route/cd_beat_select.sv
source/cd_beat_buffer.sv
source/ccu_cd_router.sv
verif/tb_clk_gen.sv
verif/tb_ccu_cd_router.sv

// ==== Bender.yml ====
package:
  name: ccu_cd_router

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ccu_cd_pkg.sv
      - common/ccu_op_pkg.sv
      - cd_route/cd_request_queue.sv
      - cd_route/cd_beat_select.sv
      - source/cd_beat_buffer.sv
      - source/ccu_cd_router.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ccu_cd_router.sv
